// ==== build.f ====
logic/racc_pkg.sv
logic/racc_stage_if.sv
logic/racc_decode.sv
logic/racc_event_flags.sv
logic/racc_respond.sv
logic/racc_event_ring.sv
test/racc_event_ring_tb.sv

// ==== logic/racc_decode.sv ====
// First stage of an event peripheral; samples the ring word and decodes it.
// Address window is set by ADDR_BASE and ADDR_MASK as byte addresses.
module racc_decode
  import racc_pkg::*;
#(
  parameter logic [19:0] ADDR_BASE = 20'hFFFE0,
  parameter logic [19:0] ADDR_MASK = 20'hFFFE0
) (
  input  logic         CLK,
  input  logic         RST,
  input  racc_word_t   ring_in,
  racc_stage_if.src    down
);

  logic             addr_match;
  logic             hit_c;
  logic [19:0]      byte_addr;

  // The ring carries word addresses, so two zero bits make the byte address
  assign byte_addr  = {ring_in.addr, 2'b00};
  assign addr_match = (byte_addr & ADDR_MASK) == (ADDR_BASE & ADDR_MASK);

  // Only requests can hit, responses to the same address pass by
  assign hit_c = (ring_in.kind == KIND_REQ) && addr_match;

  // Everything the next stage acts on is registered here
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      down.word <= RACC_IDLE_WORD;
      down.hit  <= 1'b0;
      down.wr   <= 1'b0;
      down.rd   <= 1'b0;
      down.sel  <= '0;
    end
    else
    begin
      down.word <= ring_in;
      down.hit  <= hit_c;
      // Any byte-enable code other than read or write is a plain lookup
      down.wr   <= hit_c && (ring_in.be == BE_WRITE);
      down.rd   <= hit_c && (ring_in.be == BE_READ);
      // Low address bits pick one of four flag or four mask registers
      down.sel  <= ring_in.addr[SEL_W-1:0];
    end
  end

  // The two access codes differ, so one word never asks for both
  a_wr_rd_excl: assert property (
    @(posedge CLK) disable iff (RST)
    !(down.wr && down.rd)
  );

endmodule

// ==== logic/racc_event_flags.sv ====
// Second stage of an event peripheral; holds the flag and mask registers.
// Applies the decoded access, captures read data and drives pending lines.
module racc_event_flags
  import racc_pkg::*;
(
  input  logic         CLK,
  input  logic         RST,
  racc_stage_if.dst    up,
  racc_stage_if.src    down,
  output logic [3:0]   pending
);

  // Four flag registers with 32 single-bit flags each, and their masks
  logic [3:0][31:0] flag_q;
  logic [3:0][31:0] mask_q;

  logic [1:0]       idx;
  logic [31:0]      set_bits;
  logic [31:0]      reg_val;

  // Bit 2 of the select chooses masks, the low bits pick the register
  assign idx = up.sel[1:0];

  // A write sets the flag numbered by the data
  // Any value of 32 or more leaves every flag alone
  always_comb
  begin
    if ((|up.word.data[31:6]) || up.word.data[5])
      set_bits = '0;
    else
      set_bits = 32'd1 << up.word.data[4:0];
  end

  // Value of the selected register before this cycle's access
  assign reg_val = up.sel[2] ? mask_q[idx] : flag_q[idx];

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      flag_q <= '0;
      mask_q <= '0;
    end
    else if (up.hit)
    begin
      if (up.wr)
      begin
        if (up.sel[2])
          mask_q[idx] <= up.word.data;
        else
          flag_q[idx] <= flag_q[idx] | set_bits;
      end
      // Reading a flag register clears it, reading a mask changes nothing
      else if (up.rd && !up.sel[2])
        flag_q[idx] <= '0;
    end
  end

  // Read data only matters next to a hit, so it is only loaded then
  always_ff @(posedge CLK)
  begin
    if (up.hit)
      down.rdata <= reg_val;
  end

  // The word and its hit bit move on one stage
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      down.word <= RACC_IDLE_WORD;
      down.hit  <= 1'b0;
    end
    else
    begin
      down.word <= up.word;
      down.hit  <= up.hit;
    end
  end

  // A line is high when its register holds a flag that is not masked
  // Sampled one edge after the registers change
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
      pending <= '0;
    else
    begin
      for (int i = 0; i < 4; i++)
        pending[i] <= |(flag_q[i] & ~mask_q[i]);
    end
  end

  // Words that do not hit this peripheral never touch its registers
  a_hold_no_hit: assert property (
    @(posedge CLK) disable iff (RST)
    !up.hit |=> ($stable(flag_q) && $stable(mask_q))
  );

  // A word carries one access, so a read flag register cannot be set again
  // in the same cycle and must come out empty
  a_read_clears: assert property (
    @(posedge CLK) disable iff (RST)
    (up.rd && !up.sel[2]) |=> (flag_q[$past(idx)] == '0)
  );

endmodule

// ==== logic/racc_event_ring.sv ====
// Ring segment with two event-flag peripherals, A first and B second.
// Each peripheral adds three cycles, so the segment has six in total.
module racc_event_ring
  import racc_pkg::*;
#(
  parameter logic [19:0] BASE_A = 20'hFFFE0,
  parameter logic [19:0] MASK_A = 20'hFFFE0,
  parameter logic [19:0] BASE_B = 20'hFFFC0,
  parameter logic [19:0] MASK_B = 20'hFFFE0
) (
  input  logic        CLK,
  input  logic        RST,
  input  logic [63:0] racc_in,
  output logic [63:0] racc_out,
  output logic [7:0]  event_pending
);

  // Ring word between the two peripherals
  racc_word_t ring_mid;

  // Stage links inside peripheral A
  racc_stage_if a_dec_flg ();
  racc_stage_if a_flg_rsp ();

  // Stage links inside peripheral B
  racc_stage_if b_dec_flg ();
  racc_stage_if b_flg_rsp ();

  racc_decode #(
    .ADDR_BASE (BASE_A),
    .ADDR_MASK (MASK_A)
  ) a_decode (
    .CLK     (CLK),
    .RST     (RST),
    .ring_in (racc_in),
    .down    (a_dec_flg)
  );

  racc_event_flags a_flags (
    .CLK     (CLK),
    .RST     (RST),
    .up      (a_dec_flg),
    .down    (a_flg_rsp),
    .pending (event_pending[3:0])
  );

  racc_respond a_respond (
    .CLK      (CLK),
    .RST      (RST),
    .up       (a_flg_rsp),
    .ring_out (ring_mid)
  );

  racc_decode #(
    .ADDR_BASE (BASE_B),
    .ADDR_MASK (MASK_B)
  ) b_decode (
    .CLK     (CLK),
    .RST     (RST),
    .ring_in (ring_mid),
    .down    (b_dec_flg)
  );

  racc_event_flags b_flags (
    .CLK     (CLK),
    .RST     (RST),
    .up      (b_dec_flg),
    .down    (b_flg_rsp),
    .pending (event_pending[7:4])
  );

  racc_respond b_respond (
    .CLK      (CLK),
    .RST      (RST),
    .up       (b_flg_rsp),
    .ring_out (racc_out)
  );

endmodule

// ==== logic/racc_pkg.sv ====
// Shared ring word layout and code values for the Raccoon event segment.
// Imported by every stage and by the segment top.
package racc_pkg;

  // Word kinds carried in the top two bits of a ring word
  localparam logic [1:0] KIND_IDLE = 2'b00;
  localparam logic [1:0] KIND_RESP = 2'b10;
  localparam logic [1:0] KIND_REQ  = 2'b11;

  // Only these two byte-enable codes change register state
  localparam logic [3:0] BE_READ  = 4'b0000;
  localparam logic [3:0] BE_WRITE = 4'b1111;

  // A request from this bus ID is consumed without an answer
  // This lets slave-only peripherals issue accesses without owning an ID
  localparam logic [7:0] NO_ACK_ID = 8'hFF;

  // Width of the register select taken from the low address bits
  localparam int SEL_W = 3;

  // One 64-bit ring word, top bit first
  typedef struct packed {
    logic [1:0]  kind;
    logic [7:0]  bus_id;
    logic [3:0]  be;
    logic [17:0] addr;
    logic [31:0] data;
  } racc_word_t;

  // The idle word is all zeros, which also makes its kind KIND_IDLE
  localparam racc_word_t RACC_IDLE_WORD = '{
    kind:   KIND_IDLE,
    bus_id: 8'h00,
    be:     4'h0,
    addr:   18'h0,
    data:   32'h0
  };

endpackage

// ==== logic/racc_respond.sv ====
// Third stage of an event peripheral; forms the word that leaves it.
// Passes other traffic, answers hits, or drops no-acknowledge requests.
module racc_respond
  import racc_pkg::*;
(
  input  logic         CLK,
  input  logic         RST,
  racc_stage_if.dst    up,
  output racc_word_t   ring_out
);

  racc_word_t resp_word;

  // A response keeps the request's ID, byte enables and address
  // Data is the register value captured before the access
  always_comb
  begin
    resp_word      = up.word;
    resp_word.kind = KIND_RESP;
    resp_word.data = up.rdata;
  end

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
      ring_out <= RACC_IDLE_WORD;
    else if (!up.hit)
      ring_out <= up.word;
    // The request is taken off the ring but its access already happened
    else if (up.word.bus_id == NO_ACK_ID)
      ring_out <= RACC_IDLE_WORD;
    else
      ring_out <= resp_word;
  end

  // A request that hit here must never travel further as a request
  a_hit_consumed: assert property (
    @(posedge CLK) disable iff (RST)
    up.hit |=> (ring_out.kind != KIND_REQ)
  );

endmodule

// ==== logic/racc_stage_if.sv ====
// Link between two pipeline stages of one event peripheral.
// Carries the ring word, its registered decode results and the read data.
interface racc_stage_if
  import racc_pkg::*;
();

  // The ring word as it moves down the peripheral
  racc_word_t       word;

  // Registered decode results for the word
  logic             hit;
  logic             wr;
  logic             rd;
  logic [SEL_W-1:0] sel;

  // Register value from before the access, valid next to a hit
  logic [31:0]      rdata;

  // Upstream stage side
  modport src (
    output word,
    output hit,
    output wr,
    output rd,
    output sel,
    output rdata
  );

  // Downstream stage side
  modport dst (
    input word,
    input hit,
    input wr,
    input rd,
    input sel,
    input rdata
  );

endinterface

// ==== run.sh ====
#!/bin/sh
# Compiles the ring segment and its testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f build.f --top-module racc_event_ring_tb -o racc_sim

out=$(./obj_dir/racc_sim)
echo "$out"

if echo "$out" | grep -qx "TEST PASSED"; then
  exit 0
else
  exit 1
fi

// ==== test/racc_event_ring_tb.sv ====
// Testbench for the two-peripheral event ring segment.
// Replays test/ring_cases.txt and checks racc_out and event_pending.
module racc_event_ring_tb
  import racc_pkg::*;
();

  // Ring latency through both peripherals and through peripheral A alone
  localparam int RING_LATENCY = 6;
  localparam int A_LATENCY    = 3;
  localparam int MAX_LINES    = 500;
  localparam int DRAIN_LIMIT  = 50;
  localparam string CASES_FILE = "test/ring_cases.txt";

  logic        CLK;
  logic        RST;
  logic [63:0] racc_in;
  logic [63:0] racc_out;
  logic [7:0]  event_pending;

  // Cases as read from the file
  racc_word_t  case_in_q[$];
  racc_word_t  case_out_q[$];
  logic [7:0]  case_pend_q[$];

  // Expected results for words in flight, tagged with their drive cycle
  racc_word_t  exp_word_q[$];
  logic [7:0]  exp_pend_q[$];
  int          exp_cyc_q[$];

  // Peripheral A settles earlier, so its half is checked on its own queue
  logic [7:0]  exp_a_q[$];
  int          exp_a_cyc_q[$];

  int          cycle;
  int          word_errs;
  int          pend_errs;
  int          other_errs;
  logic [31:0] lcg_state;
  logic [7:0]  last_pend;

  racc_event_ring UUT (
    .CLK           (CLK),
    .RST           (RST),
    .racc_in       (racc_in),
    .racc_out      (racc_out),
    .event_pending (event_pending)
  );

  initial
  begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  // Plain LCG step, the top bits give the idle gap length
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_word(input string name, input racc_word_t exp, input racc_word_t act);
    if (act !== exp)
    begin
      word_errs++;
      $display("FAIL %s expected %h got %h at cycle %0d", name, exp, act, cycle);
    end
  endtask

  task automatic check_pending(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp)
    begin
      pend_errs++;
      $display("FAIL %s expected %h got %h at cycle %0d", name, exp, act, cycle);
    end
  endtask

  // Reads every case line, skipping blank lines and lines that start with #
  task automatic load_cases();
    int          fd;
    int          n;
    int          code;
    string       line;
    logic [63:0] in_w;
    logic [63:0] out_w;
    logic [7:0]  pend;
    fd = $fopen(CASES_FILE, "r");
    if (fd == 0)
    begin
      other_errs++;
      $display("Could not open the cases file %s", CASES_FILE);
      return;
    end
    for (n = 0; n < MAX_LINES; n++)
    begin
      if ($feof(fd))
        break;
      code = $fgets(line, fd);
      if (code == 0)
        break;
      if (line.len() == 0 || line[0] == "#" || line[0] == "\n")
        continue;
      code = $sscanf(line, "%h %h %h", in_w, out_w, pend);
      if (code != 3)
      begin
        other_errs++;
        $display("Line %0d of the cases file could not be parsed", n + 1);
      end
      else
      begin
        case_in_q.push_back(in_w);
        case_out_q.push_back(out_w);
        case_pend_q.push_back(pend);
      end
    end
    if (n == MAX_LINES)
    begin
      other_errs++;
      $display("The cases file has more than %0d lines", MAX_LINES);
    end
    $fclose(fd);
    if (case_in_q.size() == 0)
    begin
      other_errs++;
      $display("No cases were read from the cases file");
    end
  endtask

  // Compares whatever result is due in the current cycle
  task automatic check_outputs();
    racc_word_t exp_w;
    logic [7:0] exp_p;
    // A's lines reflect a word three cycles after it was driven
    if (exp_a_q.size() > 0 && exp_a_cyc_q[0] == cycle - A_LATENCY)
    begin
      exp_p = exp_a_q.pop_front();
      void'(exp_a_cyc_q.pop_front());
      check_pending("event_pending[3:0]", {4'h0, exp_p[3:0]}, {4'h0, event_pending[3:0]});
    end
    // The word leaves the ring just as B's lines settle for it
    if (exp_word_q.size() > 0 && exp_cyc_q[0] == cycle - RING_LATENCY)
    begin
      exp_w = exp_word_q.pop_front();
      exp_p = exp_pend_q.pop_front();
      void'(exp_cyc_q.pop_front());
      check_word("racc_out", exp_w, racc_out);
      check_pending("event_pending[7:4]", {exp_p[7:4], 4'h0}, {event_pending[7:4], 4'h0});
    end
  endtask

  // One ring cycle: check outputs, then drive the next word after the edge
  task automatic step_cycle(input racc_word_t drive_word, input racc_word_t exp_out,
                            input logic [7:0] exp_pend, input logic track);
    @(posedge CLK);
    #1;
    cycle++;
    check_outputs();
    racc_in = drive_word;
    if (track)
    begin
      exp_word_q.push_back(exp_out);
      exp_pend_q.push_back(exp_pend);
      exp_cyc_q.push_back(cycle);
      exp_a_q.push_back(exp_pend);
      exp_a_cyc_q.push_back(cycle);
    end
  endtask

  initial
  begin
    int gap;
    RST        = 1'b1;
    racc_in    = '0;
    cycle      = 0;
    word_errs  = 0;
    pend_errs  = 0;
    other_errs = 0;
    lcg_state  = 32'h1205;
    last_pend  = 8'h00;
    load_cases();
    repeat (2) @(posedge CLK);
    #1;
    RST = 1'b0;
    for (int i = 0; i < case_in_q.size(); i++)
    begin
      step_cycle(case_in_q[i], case_out_q[i], case_pend_q[i], 1'b1);
      last_pend = case_pend_q[i];
      // Idle words between cases leave every register as it was
      lcg_state = lcg_next(lcg_state);
      gap = int'(lcg_state[31:30]);
      for (int g = 0; g < gap; g++)
        step_cycle(RACC_IDLE_WORD, RACC_IDLE_WORD, last_pend, 1'b1);
    end
    // Let the last words leave the ring
    for (int t = 0; t < DRAIN_LIMIT && exp_word_q.size() > 0; t++)
      step_cycle(RACC_IDLE_WORD, RACC_IDLE_WORD, last_pend, 1'b0);
    if (exp_word_q.size() > 0)
    begin
      other_errs++;
      $display("Timed out draining the ring with %0d words still expected", exp_word_q.size());
    end
    $display("Errors: %0d word, %0d pending, %0d other", word_errs, pend_errs, other_errs);
    if (word_errs + pend_errs + other_errs == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== test/ring_cases.txt ====
# Columns: input ring word, expected output ring word, expected event_pending (all hex)
# Pending bits 3:0 belong to peripheral A, bits 7:4 to peripheral B
# Pass-through of idle, response and off-window request words
0000000000000000 0000000000000000 00
8143fffa12345678 8143fffa12345678 00
d03c0100deadbeef d03c0100deadbeef 00
d003ffe800000000 d003ffe800000000 00
# Peripheral A flag register 2, set bits 0, 5 and 31, ignore 32 and above
c4bffffa00000000 84bffffa00000000 04
c4bffffa00000005 84bffffa00000001 04
c4bffffa0000001f 84bffffa00000021 04
c4bffffa00000020 84bffffa80000021 04
c4bffffa00000100 84bffffa80000021 04
c483fffa00000000 8483fffa80000021 00
c483fffa00000000 8483fffa00000000 00
# Peripheral A mask register 2
cd3ffffea5a5f00f 8d3ffffe00000000 00
cd03fffe00000000 8d03fffea5a5f00f 00
c4bffffa00000000 84bffffa00000000 00
c4bffffa00000004 84bffffa00000001 04
cd3ffffe00000011 8d3ffffea5a5f00f 00
c483fffa00000000 8483fffa00000011 00
# Flag register 0, then a byte-enable code that only reads
c4bffff800000003 84bffff800000000 01
c48ffff800000007 848ffff800000008 01
# No-acknowledge requests still change the flags
fffffffb00000001 0000000000000000 09
ffc3fff800000000 0000000000000000 08
c483fffb00000000 8483fffb00000002 00
# Peripheral B behind A
cd3ffff100000009 8d3ffff100000000 20
cd3ffff300000014 8d3ffff300000000 a0
c4bffff900000002 84bffff900000000 a2
cd3ffff500000200 8d3ffff500000000 82
cd03fff500000000 8d03fff500000200 82
cd03fff300000000 8d03fff300100000 02
cd03fff100000000 8d03fff100000200 02
c483fff900000000 8483fff900000004 00
fffffff100000000 0000000000000000 20
c483fff100000000 8483fff100000001 00
0000000000000000 0000000000000000 00
